//--- mci_cfg.svh
`ifndef MCI_CFG_SVH
`define MCI_CFG_SVH

// Bus widths of the request port
`define MCI_ADDR_W 32
`define MCI_DATA_W 32
`define MCI_USER_W 8

// One strobe bit per data byte
`define MCI_STRB_W (`MCI_DATA_W / 8)

// Target sizes in 32-bit words
`define MCI_REG_WORDS  16
`define MCI_MBOX_WORDS 32
`define MCI_SRAM_WORDS 256

// Word index wide enough for the largest target
`define MCI_IDX_W $clog2(`MCI_SRAM_WORDS)

// Byte base of each target window
`define MCI_REG_BASE   32'h0000_0000
`define MCI_MBOX0_BASE 32'h0000_1000
`define MCI_MBOX1_BASE 32'h0000_2000
`define MCI_SRAM_BASE  32'h0000_4000

`endif

//--- mci_pkg.sv
`default_nettype none

package mci_pkg;

    // Decoded destination of a request
    typedef enum logic [2:0] {
        TGT_NONE  = 3'd0,
        TGT_REG   = 3'd1,
        TGT_MBOX0 = 3'd2,
        TGT_MBOX1 = 3'd3,
        TGT_SRAM  = 3'd4
    } mci_target_e;

    // Access direction
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mci_op_e;

    // Four-phase front end states
    typedef enum logic [1:0] {
        HS_IDLE = 2'd0,
        HS_BUSY = 2'd1,
        HS_ACK  = 2'd2,
        HS_DROP = 2'd3
    } hs_state_e;

endpackage

`default_nettype wire

//--- mci_sub_handshake.sv
`default_nettype none

`include "mci_cfg.svh"

module mci_sub_handshake (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  logic [`MCI_ADDR_W-1:0] addr,
    input  logic                   write,
    input  logic [`MCI_DATA_W-1:0] wdata,
    input  logic [`MCI_STRB_W-1:0] wstrb,
    input  logic [`MCI_USER_W-1:0] user,
    input  logic                   done_pulse,
    output logic                   ack,
    output logic                   start,
    output mci_pkg::mci_op_e       op,
    output logic [`MCI_ADDR_W-1:0] cap_addr,
    output logic [`MCI_DATA_W-1:0] cap_wdata,
    output logic [`MCI_STRB_W-1:0] cap_wstrb,
    output logic [`MCI_USER_W-1:0] cap_user
);
    import mci_pkg::*;

    hs_state_e state;

    // Control FSM
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= HS_IDLE;
            ack   <= 1'b0;
            start <= 1'b0;
        end else begin
            // Start is a single-cycle pulse
            start <= 1'b0;
            case (state)
                HS_IDLE: begin
                    if (req) begin
                        state <= HS_BUSY;
                        start <= 1'b1;
                    end
                end
                HS_BUSY: begin
                    // Wait for the result step
                    if (done_pulse) begin
                        state <= HS_ACK;
                        ack   <= 1'b1;
                    end
                end
                HS_ACK: begin
                    // Master may stall here as long as it likes
                    if (!req) begin
                        state <= HS_DROP;
                        ack   <= 1'b0;
                    end
                end
                HS_DROP: state <= HS_IDLE;
                default: state <= HS_IDLE;
            endcase
        end
    end

    // Payload capture at the accepting edge
    always_ff @(posedge clk) begin
        if (state == HS_IDLE && req) begin
            op        <= write ? OP_WRITE : OP_READ;
            cap_addr  <= addr;
            cap_wdata <= wdata;
            cap_wstrb <= wstrb;
            cap_user  <= user;
        end
    end

    // A new request only leaves the idle state
    a_start_from_idle: assert property (@(posedge clk) disable iff (reset)
        start |-> $past(state) == HS_IDLE);

    // Ack is always answered by the result step first
    a_ack_after_done: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(done_pulse));

endmodule

`default_nettype wire

//--- mci_axi_sub_decode.sv
`default_nettype none

`include "mci_cfg.svh"

module mci_axi_sub_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  mci_pkg::mci_op_e       op,
    input  logic [`MCI_ADDR_W-1:0] addr,
    input  logic [`MCI_DATA_W-1:0] wdata,
    input  logic [`MCI_STRB_W-1:0] wstrb,
    input  logic [`MCI_USER_W-1:0] user,
    input  logic [`MCI_USER_W-1:0] strap_mcu_lsu_axi_user,
    input  logic [`MCI_USER_W-1:0] strap_mcu_ifu_axi_user,
    input  logic [`MCI_USER_W-1:0] strap_clp_axi_user,
    output logic                   exec_valid,
    output mci_pkg::mci_target_e   target,
    output logic [`MCI_IDX_W-1:0]  index,
    output mci_pkg::mci_op_e       exec_op,
    output logic [`MCI_DATA_W-1:0] exec_wdata,
    output logic [`MCI_STRB_W-1:0] exec_wstrb,
    output logic                   deny,
    output logic                   mcu_lsu_req,
    output logic                   mcu_ifu_req,
    output logic                   mcu_req,
    output logic                   clp_req,
    output logic                   soc_req
);
    import mci_pkg::*;

    mci_target_e            tgt_d;
    logic [`MCI_ADDR_W-1:0] offset;
    logic                   lsu_hit;
    logic                   ifu_hit;
    logic                   clp_hit;
    logic                   soc_hit;
    logic                   deny_d;

    // True when a lies inside [base, base + bytes)
    function automatic logic in_window(input logic [`MCI_ADDR_W-1:0] a,
                                       input logic [`MCI_ADDR_W-1:0] base,
                                       input logic [`MCI_ADDR_W-1:0] bytes);
        return (a >= base) && (a < base + bytes);
    endfunction

    // Address map
    always_comb begin
        tgt_d  = TGT_NONE;
        offset = '0;
        if (in_window(addr, `MCI_REG_BASE, `MCI_REG_WORDS * 4)) begin
            tgt_d  = TGT_REG;
            offset = addr - `MCI_REG_BASE;
        end else if (in_window(addr, `MCI_MBOX0_BASE, `MCI_MBOX_WORDS * 4)) begin
            tgt_d  = TGT_MBOX0;
            offset = addr - `MCI_MBOX0_BASE;
        end else if (in_window(addr, `MCI_MBOX1_BASE, `MCI_MBOX_WORDS * 4)) begin
            tgt_d  = TGT_MBOX1;
            offset = addr - `MCI_MBOX1_BASE;
        end else if (in_window(addr, `MCI_SRAM_BASE, `MCI_SRAM_WORDS * 4)) begin
            tgt_d  = TGT_SRAM;
            offset = addr - `MCI_SRAM_BASE;
        end
    end

    // Requester class by priority lsu then ifu then clp
    assign lsu_hit = (user == strap_mcu_lsu_axi_user);
    assign ifu_hit = !lsu_hit && (user == strap_mcu_ifu_axi_user);
    assign clp_hit = !lsu_hit && !ifu_hit && (user == strap_clp_axi_user);
    assign soc_hit = !(lsu_hit || ifu_hit || clp_hit);

    // Unmapped, SoC register writes and non-MCU SRAM access are refused
    assign deny_d = (tgt_d == TGT_NONE) ||
                    (tgt_d == TGT_REG && op == OP_WRITE && soc_hit) ||
                    (tgt_d == TGT_SRAM && !(lsu_hit || ifu_hit));

    // Control and flags
    always_ff @(posedge clk) begin
        if (reset) begin
            exec_valid  <= 1'b0;
            target      <= TGT_NONE;
            deny        <= 1'b0;
            mcu_lsu_req <= 1'b0;
            mcu_ifu_req <= 1'b0;
            mcu_req     <= 1'b0;
            clp_req     <= 1'b0;
            soc_req     <= 1'b0;
        end else begin
            exec_valid <= start;
            if (start) begin
                target      <= tgt_d;
                deny        <= deny_d;
                mcu_lsu_req <= lsu_hit;
                mcu_ifu_req <= ifu_hit;
                mcu_req     <= lsu_hit || ifu_hit;
                clp_req     <= clp_hit;
                soc_req     <= soc_hit;
            end
        end
    end

    // Payload toward execute held until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            index      <= offset[`MCI_IDX_W+1:2];
            exec_op    <= op;
            exec_wdata <= wdata;
            exec_wstrb <= wstrb;
        end
    end

    // Flags of the request are in place while execute sees it
    a_one_class: assert property (@(posedge clk) disable iff (reset)
        exec_valid |-> $onehot({mcu_req, clp_req, soc_req}));

endmodule

`default_nettype wire

//--- mci_target_exec.sv
`default_nettype none

`include "mci_cfg.svh"

module mci_target_exec (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   exec_valid,
    input  mci_pkg::mci_target_e   target,
    input  logic [`MCI_IDX_W-1:0]  index,
    input  mci_pkg::mci_op_e       exec_op,
    input  logic [`MCI_DATA_W-1:0] exec_wdata,
    input  logic [`MCI_STRB_W-1:0] exec_wstrb,
    input  logic                   deny,
    output logic                   done,
    output logic [`MCI_DATA_W-1:0] rdata,
    output logic                   error
);
    import mci_pkg::*;

    localparam int REG_IW  = $clog2(`MCI_REG_WORDS);
    localparam int MBOX_IW = $clog2(`MCI_MBOX_WORDS);

    logic [`MCI_DATA_W-1:0] reg_mem   [`MCI_REG_WORDS];
    logic [`MCI_DATA_W-1:0] mbox0_mem [`MCI_MBOX_WORDS];
    logic [`MCI_DATA_W-1:0] mbox1_mem [`MCI_MBOX_WORDS];
    logic [`MCI_DATA_W-1:0] sram_mem  [`MCI_SRAM_WORDS];

    logic                   sweep_busy;
    logic [`MCI_IDX_W-1:0]  sweep_idx;
    logic                   pending;
    logic                   go;
    logic                   wr_en;
    logic [`MCI_DATA_W-1:0] rd_word;

    // Keep old bytes where the strobe is low
    function automatic logic [`MCI_DATA_W-1:0] merge_bytes(
        input logic [`MCI_DATA_W-1:0] old_word,
        input logic [`MCI_DATA_W-1:0] new_word,
        input logic [`MCI_STRB_W-1:0] strb);
        logic [`MCI_DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < `MCI_STRB_W; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // Requests park in pending while the clear sweep runs
    assign go    = (exec_valid || pending) && !sweep_busy;
    assign wr_en = go && !deny && (exec_op == OP_WRITE);

    // Word of the selected target
    always_comb begin
        case (target)
            TGT_REG:   rd_word = reg_mem[index[REG_IW-1:0]];
            TGT_MBOX0: rd_word = mbox0_mem[index[MBOX_IW-1:0]];
            TGT_MBOX1: rd_word = mbox1_mem[index[MBOX_IW-1:0]];
            TGT_SRAM:  rd_word = sram_mem[index];
            default:   rd_word = '0;
        endcase
    end

    // Sweep, pending and completion control
    always_ff @(posedge clk) begin
        if (reset) begin
            sweep_busy <= 1'b1;
            sweep_idx  <= '0;
            pending    <= 1'b0;
            done       <= 1'b0;
            error      <= 1'b0;
        end else begin
            done    <= go;
            pending <= (exec_valid || pending) && sweep_busy;
            if (sweep_busy) begin
                sweep_idx <= sweep_idx + 1'b1;
                if (sweep_idx == `MCI_IDX_W'(`MCI_SRAM_WORDS - 1)) begin
                    sweep_busy <= 1'b0;
                end
            end
            if (go) begin
                error <= deny;
            end
        end
    end

    // Storage and read data
    always_ff @(posedge clk) begin
        if (sweep_busy) begin
            // Smaller arrays only take the low part of the sweep
            if (sweep_idx < `MCI_REG_WORDS) begin
                reg_mem[sweep_idx[REG_IW-1:0]] <= '0;
            end
            if (sweep_idx < `MCI_MBOX_WORDS) begin
                mbox0_mem[sweep_idx[MBOX_IW-1:0]] <= '0;
                mbox1_mem[sweep_idx[MBOX_IW-1:0]] <= '0;
            end
            sram_mem[sweep_idx] <= '0;
        end else if (wr_en) begin
            case (target)
                TGT_REG: reg_mem[index[REG_IW-1:0]] <=
                    merge_bytes(rd_word, exec_wdata, exec_wstrb);
                TGT_MBOX0: mbox0_mem[index[MBOX_IW-1:0]] <=
                    merge_bytes(rd_word, exec_wdata, exec_wstrb);
                TGT_MBOX1: mbox1_mem[index[MBOX_IW-1:0]] <=
                    merge_bytes(rd_word, exec_wdata, exec_wstrb);
                TGT_SRAM: sram_mem[index] <=
                    merge_bytes(rd_word, exec_wdata, exec_wstrb);
                default: ;
            endcase
        end
        // Writes and refused accesses return zero
        if (go) begin
            rdata <= (!deny && exec_op == OP_READ) ? rd_word : '0;
        end
    end

endmodule

`default_nettype wire

//--- mci_sub_result.sv
`default_nettype none

`include "mci_cfg.svh"

module mci_sub_result (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   done,
    input  logic [`MCI_DATA_W-1:0] rdata,
    input  logic                   error,
    input  logic                   dec_mcu_lsu_req,
    input  logic                   dec_mcu_ifu_req,
    input  logic                   dec_mcu_req,
    input  logic                   dec_clp_req,
    input  logic                   dec_soc_req,
    input  logic                   exec_valid,
    output logic                   done_pulse,
    output logic [`MCI_DATA_W-1:0] rsp_rdata,
    output logic                   rsp_error,
    output logic                   mcu_lsu_req,
    output logic                   mcu_ifu_req,
    output logic                   mcu_req,
    output logic                   clp_req,
    output logic                   soc_req
);

    // Flags of the request in flight
    logic [4:0] flags_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            flags_q     <= '0;
            done_pulse  <= 1'b0;
            rsp_rdata   <= '0;
            rsp_error   <= 1'b0;
            mcu_lsu_req <= 1'b0;
            mcu_ifu_req <= 1'b0;
            mcu_req     <= 1'b0;
            clp_req     <= 1'b0;
            soc_req     <= 1'b0;
        end else begin
            done_pulse <= done;
            if (exec_valid) begin
                flags_q <= {dec_mcu_lsu_req, dec_mcu_ifu_req, dec_mcu_req,
                            dec_clp_req, dec_soc_req};
            end
            // Response and flags switch together and hold till the next one
            if (done) begin
                rsp_rdata <= rdata;
                rsp_error <= error;
                {mcu_lsu_req, mcu_ifu_req, mcu_req, clp_req, soc_req} <= flags_q;
            end
        end
    end

    // Every completion belongs to its own request
    a_done_per_request: assert property (@(posedge clk) disable iff (reset)
        done |=> !done until exec_valid);

endmodule

`default_nettype wire

//--- mci_sub_top.sv
`default_nettype none

`include "mci_cfg.svh"

module mci_sub_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  logic [`MCI_ADDR_W-1:0] addr,
    input  logic                   write,
    input  logic [`MCI_DATA_W-1:0] wdata,
    input  logic [`MCI_STRB_W-1:0] wstrb,
    input  logic [`MCI_USER_W-1:0] user,
    input  logic [`MCI_USER_W-1:0] strap_mcu_lsu_axi_user,
    input  logic [`MCI_USER_W-1:0] strap_mcu_ifu_axi_user,
    input  logic [`MCI_USER_W-1:0] strap_clp_axi_user,
    output logic                   ack,
    output logic [`MCI_DATA_W-1:0] rdata,
    output logic                   error,
    output logic                   mcu_lsu_req,
    output logic                   mcu_ifu_req,
    output logic                   mcu_req,
    output logic                   clp_req,
    output logic                   soc_req
);
    import mci_pkg::*;

    // Handshake to decode
    logic                   start;
    mci_op_e                op;
    logic [`MCI_ADDR_W-1:0] cap_addr;
    logic [`MCI_DATA_W-1:0] cap_wdata;
    logic [`MCI_STRB_W-1:0] cap_wstrb;
    logic [`MCI_USER_W-1:0] cap_user;

    // Decode to execute
    logic                   exec_valid;
    mci_target_e            target;
    logic [`MCI_IDX_W-1:0]  index;
    mci_op_e                exec_op;
    logic [`MCI_DATA_W-1:0] exec_wdata;
    logic [`MCI_STRB_W-1:0] exec_wstrb;
    logic                   deny;

    // Decode flags to result
    logic dec_mcu_lsu_req;
    logic dec_mcu_ifu_req;
    logic dec_mcu_req;
    logic dec_clp_req;
    logic dec_soc_req;

    // Execute to result, result back to handshake
    logic                   done;
    logic [`MCI_DATA_W-1:0] exec_rdata;
    logic                   exec_error;
    logic                   done_pulse;

    mci_sub_handshake mci_sub_handshake_i (
        .clk, .reset, .req, .addr, .write, .wdata, .wstrb, .user,
        .done_pulse, .ack, .start, .op,
        .cap_addr, .cap_wdata, .cap_wstrb, .cap_user
    );

    mci_axi_sub_decode mci_axi_sub_decode_i (
        .clk, .reset, .start, .op,
        .addr (cap_addr),
        .wdata(cap_wdata),
        .wstrb(cap_wstrb),
        .user (cap_user),
        .strap_mcu_lsu_axi_user, .strap_mcu_ifu_axi_user, .strap_clp_axi_user,
        .exec_valid, .target, .index, .exec_op, .exec_wdata, .exec_wstrb, .deny,
        .mcu_lsu_req(dec_mcu_lsu_req),
        .mcu_ifu_req(dec_mcu_ifu_req),
        .mcu_req    (dec_mcu_req),
        .clp_req    (dec_clp_req),
        .soc_req    (dec_soc_req)
    );

    mci_target_exec mci_target_exec_i (
        .clk, .reset, .exec_valid, .target, .index,
        .exec_op, .exec_wdata, .exec_wstrb, .deny, .done,
        .rdata(exec_rdata),
        .error(exec_error)
    );

    mci_sub_result mci_sub_result_i (
        .clk, .reset, .done,
        .rdata(exec_rdata),
        .error(exec_error),
        .dec_mcu_lsu_req, .dec_mcu_ifu_req, .dec_mcu_req, .dec_clp_req, .dec_soc_req,
        .exec_valid, .done_pulse,
        .rsp_rdata(rdata),
        .rsp_error(error),
        .mcu_lsu_req, .mcu_ifu_req, .mcu_req, .clp_req, .soc_req
    );

endmodule

`default_nettype wire

//--- tb_mci_sub.sv
`default_nettype none

`include "mci_cfg.svh"

module tb_mci_sub;
    timeunit 1ns;
    timeprecision 100ps;

    // Strap values and a user that matches none of them
    localparam logic [7:0] S_LSU = 8'h11;
    localparam logic [7:0] S_IFU = 8'h22;
    localparam logic [7:0] S_CLP = 8'h33;
    localparam logic [7:0] U_SOC = 8'h5A;

    localparam int N_DIRECTED      = 31;
    localparam int N_RANDOM        = 300;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 20 + 500;

    logic                   clk;
    logic                   reset;
    logic                   req;
    logic [`MCI_ADDR_W-1:0] addr;
    logic                   write;
    logic [`MCI_DATA_W-1:0] wdata;
    logic [`MCI_STRB_W-1:0] wstrb;
    logic [`MCI_USER_W-1:0] user;
    logic [`MCI_USER_W-1:0] strap_mcu_lsu_axi_user;
    logic [`MCI_USER_W-1:0] strap_mcu_ifu_axi_user;
    logic [`MCI_USER_W-1:0] strap_clp_axi_user;
    logic                   ack;
    logic [`MCI_DATA_W-1:0] rdata;
    logic                   error;
    logic                   mcu_lsu_req;
    logic                   mcu_ifu_req;
    logic                   mcu_req;
    logic                   clp_req;
    logic                   soc_req;

    // Shadow copies of the four targets
    logic [`MCI_DATA_W-1:0] reg_sh   [`MCI_REG_WORDS];
    logic [`MCI_DATA_W-1:0] mbox0_sh [`MCI_MBOX_WORDS];
    logic [`MCI_DATA_W-1:0] mbox1_sh [`MCI_MBOX_WORDS];
    logic [`MCI_DATA_W-1:0] sram_sh  [`MCI_SRAM_WORDS];

    // Expected responses in request order
    logic [31:0] exp_rdata_q [$];
    logic        exp_error_q [$];
    logic [4:0]  exp_flags_q [$];
    logic [4:0]  cmp_flags;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    bit ack_last;
    bit sweep_ok;

    mci_sub_top mci_sub_top_i (
        .clk, .reset, .req, .addr, .write, .wdata, .wstrb, .user,
        .strap_mcu_lsu_axi_user, .strap_mcu_ifu_axi_user, .strap_clp_axi_user,
        .ack, .rdata, .error,
        .mcu_lsu_req, .mcu_ifu_req, .mcu_req, .clp_req, .soc_req
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Expected response of one access with shadow update on allowed writes
    function automatic void ref_access(
        input  logic [31:0] a,
        input  logic        wr,
        input  logic [31:0] wd,
        input  logic [3:0]  ws,
        input  logic [7:0]  u,
        output logic [31:0] rd,
        output logic        err,
        output logic [4:0]  flags);
        int          tgt;
        int          idx;
        logic        lsu;
        logic        ifu;
        logic        clp;
        logic        soc;
        logic [31:0] old_w;
        logic [31:0] new_w;
        // Target 0 means unmapped
        tgt = 0;
        idx = 0;
        if (a >= `MCI_REG_BASE && a < `MCI_REG_BASE + `MCI_REG_WORDS * 4) begin
            tgt = 1;
            idx = int'((a - `MCI_REG_BASE) >> 2);
        end else if (a >= `MCI_MBOX0_BASE && a < `MCI_MBOX0_BASE + `MCI_MBOX_WORDS * 4) begin
            tgt = 2;
            idx = int'((a - `MCI_MBOX0_BASE) >> 2);
        end else if (a >= `MCI_MBOX1_BASE && a < `MCI_MBOX1_BASE + `MCI_MBOX_WORDS * 4) begin
            tgt = 3;
            idx = int'((a - `MCI_MBOX1_BASE) >> 2);
        end else if (a >= `MCI_SRAM_BASE && a < `MCI_SRAM_BASE + `MCI_SRAM_WORDS * 4) begin
            tgt = 4;
            idx = int'((a - `MCI_SRAM_BASE) >> 2);
        end
        // Strap priority lsu then ifu then clp
        lsu   = (u == S_LSU);
        ifu   = !lsu && (u == S_IFU);
        clp   = !lsu && !ifu && (u == S_CLP);
        soc   = !(lsu || ifu || clp);
        flags = {lsu, ifu, lsu || ifu, clp, soc};
        err   = (tgt == 0) || (tgt == 1 && wr && soc) || (tgt == 4 && !(lsu || ifu));
        case (tgt)
            1:       old_w = reg_sh[idx];
            2:       old_w = mbox0_sh[idx];
            3:       old_w = mbox1_sh[idx];
            4:       old_w = sram_sh[idx];
            default: old_w = '0;
        endcase
        // Byte merge under the strobe
        new_w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (ws[b]) begin
                new_w[b*8 +: 8] = wd[b*8 +: 8];
            end
        end
        if (wr && !err) begin
            case (tgt)
                1:       reg_sh[idx] = new_w;
                2:       mbox0_sh[idx] = new_w;
                3:       mbox1_sh[idx] = new_w;
                4:       sram_sh[idx] = new_w;
                default: ;
            endcase
        end
        rd = (wr || err) ? '0 : old_w;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] expv,
                                 input logic [31:0] gotv);
        checks++;
        assert (gotv === expv) else begin
            errors++;
            $display("mismatch at %0d ns: %s expected %h got %h", $time, name, expv, gotv);
        end
    endtask

    // Response check at every rising ack
    always @(negedge clk) begin
        if (ack === 1'b1 && !ack_last) begin
            checks++;
            assert (exp_rdata_q.size() != 0) else begin
                errors++;
                $display("ack rose at %0d ns with no request outstanding", $time);
            end
            if (exp_rdata_q.size() != 0) begin
                cmp_flags = exp_flags_q.pop_front();
                compare_field("rdata", exp_rdata_q.pop_front(), rdata);
                compare_field("error", 32'(exp_error_q.pop_front()), 32'(error));
                compare_field("mcu_lsu_req", 32'(cmp_flags[4]), 32'(mcu_lsu_req));
                compare_field("mcu_ifu_req", 32'(cmp_flags[3]), 32'(mcu_ifu_req));
                compare_field("mcu_req", 32'(cmp_flags[2]), 32'(mcu_req));
                compare_field("clp_req", 32'(cmp_flags[1]), 32'(clp_req));
                compare_field("soc_req", 32'(cmp_flags[0]), 32'(soc_req));
            end
        end
        ack_last = (ack === 1'b1);
    end

    // One four-phase transfer where hold extends the time req stays high after ack
    task automatic run_txn(input logic [31:0] a, input logic wr, input logic [31:0] wd,
                           input logic [3:0] ws, input logic [7:0] u, input int hold);
        logic [31:0] e_rd;
        logic        e_err;
        logic [4:0]  e_fl;
        int          waited;
        ref_access(a, wr, wd, ws, u, e_rd, e_err, e_fl);
        exp_rdata_q.push_back(e_rd);
        exp_error_q.push_back(e_err);
        exp_flags_q.push_back(e_fl);
        @(negedge clk);
        req   = 1'b1;
        addr  = a;
        write = wr;
        wdata = wd;
        wstrb = ws;
        user  = u;
        // Next rising edge accepts and ack shows at the fifth falling edge
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (ack !== 1'b1 && waited < 40);
        checks++;
        assert (waited == 5 && ack === 1'b1) else begin
            errors++;
            $display("ack for address %h did not rise 4 cycles after acceptance (waited %0d)",
                     a, waited - 1);
        end
        repeat (hold) begin
            @(negedge clk);
            checks++;
            assert (ack === 1'b1) else begin
                errors++;
                $display("ack dropped at %0d ns while req was still high", $time);
            end
        end
        req = 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (ack !== 1'b0 && waited < 40);
        checks++;
        assert (waited == 1) else begin
            errors++;
            $display("ack fell %0d cycles after req fell instead of 1", waited);
        end
    endtask

    task automatic write_read(input logic [31:0] a, input logic [7:0] u);
        run_txn(a, 1'b1, $urandom, 4'hF, u, 0);
        run_txn(a, 1'b0, 32'h0, 4'h0, u, 0);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errs_before);
        end
    endtask

    // SRAM clear sweep must end within 300 cycles
    task automatic wait_sweep(output bit ok);
        int n;
        n = 0;
        while (mci_sub_top_i.mci_target_exec_i.sweep_busy && n < 300) begin
            @(negedge clk);
            n++;
        end
        ok = !mci_sub_top_i.mci_target_exec_i.sweep_busy;
        assert (ok) else begin
            errors++;
            $display("memory clear sweep still running after 300 cycles");
        end
    endtask

    task automatic test_handshake();
        int e0;
        e0 = errors;
        // Outputs quiet after reset
        compare_field("ack", 32'h0, 32'(ack));
        compare_field("rdata", 32'h0, rdata);
        compare_field("error", 32'h0, 32'(error));
        compare_field("mcu_lsu_req", 32'h0, 32'(mcu_lsu_req));
        compare_field("mcu_ifu_req", 32'h0, 32'(mcu_ifu_req));
        compare_field("mcu_req", 32'h0, 32'(mcu_req));
        compare_field("clp_req", 32'h0, 32'(clp_req));
        compare_field("soc_req", 32'h0, 32'(soc_req));
        run_txn(`MCI_REG_BASE + 32'h8, 1'b1, 32'hCAFE_0001, 4'hF, S_LSU, 0);
        run_txn(`MCI_REG_BASE + 32'h8, 1'b0, 32'h0, 4'h0, S_LSU, 6);
        repeat (10) begin
            @(negedge clk);
            checks++;
            assert (ack === 1'b0) else begin
                errors++;
                $display("ack rose at %0d ns while req was low", $time);
            end
        end
        finish_test("handshake timing", e0);
    endtask

    task automatic test_full_word();
        int e0;
        e0 = errors;
        write_read(`MCI_REG_BASE + 32'h14, S_LSU);
        write_read(`MCI_MBOX0_BASE + 32'h7C, S_IFU);
        write_read(`MCI_MBOX1_BASE + 32'h0, S_LSU);
        write_read(`MCI_SRAM_BASE + 32'h3FC, S_IFU);
        finish_test("full word per target", e0);
    endtask

    task automatic test_strobes();
        int e0;
        e0 = errors;
        run_txn(`MCI_MBOX1_BASE + 32'h24, 1'b1, 32'h1122_3344, 4'hF, S_LSU, 0);
        run_txn(`MCI_MBOX1_BASE + 32'h24, 1'b1, 32'hAABB_CCDD, 4'b0101, S_LSU, 0);
        run_txn(`MCI_MBOX1_BASE + 32'h24, 1'b0, 32'h0, 4'h0, S_LSU, 0);
        run_txn(`MCI_MBOX1_BASE + 32'h24, 1'b1, 32'h9988_7766, 4'b1000, S_IFU, 0);
        run_txn(`MCI_MBOX1_BASE + 32'h24, 1'b0, 32'h0, 4'h0, S_IFU, 0);
        run_txn(`MCI_SRAM_BASE + 32'h44, 1'b1, 32'h5566_7788, 4'b0110, S_LSU, 0);
        run_txn(`MCI_SRAM_BASE + 32'h44, 1'b0, 32'h0, 4'h0, S_LSU, 0);
        finish_test("partial strobes", e0);
    endtask

    task automatic test_privilege();
        int e0;
        e0 = errors;
        // SoC register write is refused and the old value stays
        run_txn(`MCI_REG_BASE + 32'h8, 1'b1, 32'h1234_5678, 4'hF, S_LSU, 0);
        run_txn(`MCI_REG_BASE + 32'h8, 1'b1, 32'hDEAD_BEEF, 4'hF, U_SOC, 0);
        run_txn(`MCI_REG_BASE + 32'h8, 1'b0, 32'h0, 4'h0, S_LSU, 0);
        run_txn(`MCI_REG_BASE + 32'h8, 1'b1, 32'h0BAD_F00D, 4'hF, S_CLP, 0);
        run_txn(`MCI_REG_BASE + 32'h8, 1'b0, 32'h0, 4'h0, U_SOC, 0);
        // SRAM belongs to the MCU only
        run_txn(`MCI_SRAM_BASE + 32'h3FC, 1'b1, 32'h0F0F_0F0F, 4'hF, S_CLP, 0);
        run_txn(`MCI_SRAM_BASE + 32'h3FC, 1'b0, 32'h0, 4'h0, S_CLP, 0);
        run_txn(`MCI_SRAM_BASE + 32'h3FC, 1'b0, 32'h0, 4'h0, U_SOC, 0);
        run_txn(`MCI_SRAM_BASE + 32'h3FC, 1'b0, 32'h0, 4'h0, S_IFU, 0);
        finish_test("privilege rules", e0);
    endtask

    task automatic test_unmapped();
        int e0;
        e0 = errors;
        run_txn(32'h0000_0040, 1'b0, 32'h0, 4'h0, S_LSU, 0);
        run_txn(32'h0000_1080, 1'b1, 32'h7777_7777, 4'hF, S_LSU, 0);
        run_txn(32'h0000_3000, 1'b0, 32'h0, 4'h0, S_CLP, 0);
        run_txn(32'h0000_4400, 1'b0, 32'h0, 4'h0, S_IFU, 0);
        run_txn(32'hFFFF_FFFC, 1'b0, 32'h0, 4'h0, U_SOC, 0);
        finish_test("unmapped addresses", e0);
    endtask

    task automatic test_random();
        int          e0;
        logic [31:0] a;
        logic [7:0]  u;
        e0 = errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            // Mostly mapped addresses with SRAM weighted
            case ($urandom_range(0, 9))
                0, 1:    a = `MCI_REG_BASE + 4 * $urandom_range(0, `MCI_REG_WORDS - 1);
                2:       a = `MCI_MBOX0_BASE + 4 * $urandom_range(0, `MCI_MBOX_WORDS - 1);
                3:       a = `MCI_MBOX1_BASE + 4 * $urandom_range(0, `MCI_MBOX_WORDS - 1);
                4, 5, 6: a = `MCI_SRAM_BASE + 4 * $urandom_range(0, `MCI_SRAM_WORDS - 1);
                default: a = $urandom & 32'h0000_5FFC;
            endcase
            a = a | 32'($urandom_range(0, 3));
            case ($urandom_range(0, 4))
                0:       u = S_LSU;
                1:       u = S_IFU;
                2:       u = S_CLP;
                3:       u = U_SOC;
                default: u = 8'($urandom_range(0, 255));
            endcase
            run_txn(a, 1'($urandom_range(0, 1)), $urandom, 4'($urandom_range(0, 15)), u,
                    $urandom_range(0, 2));
        end
        finish_test("random traffic", e0);
    endtask

    initial begin
        void'($urandom(55267));
        reset                  = 1'b1;
        req                    = 1'b0;
        addr                   = '0;
        write                  = 1'b0;
        wdata                  = '0;
        wstrb                  = '0;
        user                   = '0;
        strap_mcu_lsu_axi_user = S_LSU;
        strap_mcu_ifu_axi_user = S_IFU;
        strap_clp_axi_user     = S_CLP;
        errors                 = 0;
        checks                 = 0;
        tests_run              = 0;
        tests_failed           = 0;
        ack_last               = 1'b0;
        // DUT storage comes up cleared
        for (int i = 0; i < `MCI_REG_WORDS; i++) reg_sh[i] = '0;
        for (int i = 0; i < `MCI_MBOX_WORDS; i++) mbox0_sh[i] = '0;
        for (int i = 0; i < `MCI_MBOX_WORDS; i++) mbox1_sh[i] = '0;
        for (int i = 0; i < `MCI_SRAM_WORDS; i++) sram_sh[i] = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        wait_sweep(sweep_ok);
        if (sweep_ok) begin
            test_handshake();
            test_full_word();
            test_strobes();
            test_privilege();
            test_unmapped();
            test_random();
        end
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Run length bound from the transaction count
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("handshake hung: run not finished within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
mci_pkg.sv
mci_sub_handshake.sv
mci_axi_sub_decode.sv
mci_target_exec.sv
mci_sub_result.sv
mci_sub_top.sv
tb_mci_sub.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, verdict taken from the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_mci_sub

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
else
    echo "pass line not found in $LOG"
    exit 1
fi
